//--- Bender.yml
package:
  name: alu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/alu_pkg.sv
      - logic/alu_exec_if.sv
      - logic/alu_cond_eval.sv
      - logic/alu_decode.sv
      - logic/alu_datapath.sv
      - logic/alu_result_reg.sv
      - logic/alu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/alu_tb.sv

//--- include/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand and result width
`define ALU_DATA_W 16

// flag vector width, v n c z
`define ALU_FLAG_W 4

// branch condition code width
`define ALU_COND_W 4

// opcode width as seen on alu_control
`define ALU_OP_W 8

`endif

//--- logic/alu_cond_eval.sv
`timescale 1ns/10ps
`default_nettype none

module alu_cond_eval (
    input  alu_pkg::alu_flags_t flags_in,
    input  alu_pkg::alu_cond_e  condition,
    output logic                take
);

    always_comb begin
        take = 1'b0;
        case (condition)
            alu_pkg::COND_ALWAYS: take = 1'b1;
            alu_pkg::COND_NEVER:  take = 1'b0;
            alu_pkg::COND_EQ:     take = flags_in.z;
            alu_pkg::COND_NE:     take = ~flags_in.z;
            alu_pkg::COND_CS:     take = flags_in.c;
            alu_pkg::COND_CC:     take = ~flags_in.c;
            alu_pkg::COND_OS:     take = flags_in.v;
            alu_pkg::COND_OC:     take = ~flags_in.v;
            alu_pkg::COND_P:      take = ~flags_in.n;
            alu_pkg::COND_N:      take = flags_in.n;
            // unsigned compares
            alu_pkg::COND_HI:     take = ~flags_in.c & ~flags_in.z;
            alu_pkg::COND_LS:     take = flags_in.c | flags_in.z;
            // signed compares
            alu_pkg::COND_GE:     take = ~(flags_in.n ^ flags_in.v);
            alu_pkg::COND_L:      take = flags_in.n ^ flags_in.v;
            alu_pkg::COND_G:      take = ~flags_in.z & ~(flags_in.n ^ flags_in.v);
            alu_pkg::COND_LE:     take = flags_in.z | (flags_in.n ^ flags_in.v);
            default:              take = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/alu_datapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_defines.svh"

module alu_datapath (
    input  alu_pkg::alu_op_e        op,
    input  logic                    en_imm,
    input  logic                    mem_displacement,
    input  logic [`ALU_DATA_W-1:0]  rd_data,
    input  logic [`ALU_DATA_W-1:0]  rs_data,
    input  logic [`ALU_DATA_W-1:0]  immediate,
    input  alu_pkg::alu_flags_t     flags_in,
    input  logic                    take,
    alu_exec_if.datapath            exec
);

    logic [`ALU_DATA_W-1:0]   a;
    logic [`ALU_DATA_W-1:0]   b;
    logic [`ALU_DATA_W:0]     a_ext;
    logic [`ALU_DATA_W:0]     b_ext;
    logic [`ALU_DATA_W:0]     c_ext;
    logic [`ALU_DATA_W-1:0]   sar_res;
    logic [2*`ALU_DATA_W-1:0] rol_wide;
    logic [`ALU_DATA_W-1:0]   jump_target;
    logic [`ALU_DATA_W-1:0]   mem_addr;
    logic                     subtract;

    // operand select
    assign a = rd_data;
    assign b = en_imm ? immediate : rs_data;

    // zero extended so bit 16 catches the carry or borrow
    assign a_ext = {1'b0, a};
    assign b_ext = {1'b0, b};
    assign c_ext = {{`ALU_DATA_W{1'b0}}, flags_in.c};

    assign sar_res     = $signed(a) >>> b[3:0];
    // upper half of the doubled word is the rotated value
    assign rol_wide    = {a, a} << b[3:0];
    assign jump_target = en_imm ? immediate : a;
    assign mem_addr    = mem_displacement ? (rs_data + immediate) : b;

    assign subtract = (op == alu_pkg::OP_SUB) || (op == alu_pkg::OP_SBB) ||
                      (op == alu_pkg::OP_CMP);

    always_comb begin
        case (op)
            alu_pkg::OP_ADD:  exec.next_result = a_ext + b_ext;
            alu_pkg::OP_SUB,
            alu_pkg::OP_CMP:  exec.next_result = a_ext - b_ext;
            alu_pkg::OP_ADC:  exec.next_result = a_ext + b_ext + c_ext;
            alu_pkg::OP_SBB:  exec.next_result = a_ext - b_ext - c_ext;
            alu_pkg::OP_MOV:  exec.next_result = b_ext;
            alu_pkg::OP_AND,
            alu_pkg::OP_TEST: exec.next_result = {1'b0, a & b};
            alu_pkg::OP_OR:   exec.next_result = {1'b0, a | b};
            alu_pkg::OP_XOR:  exec.next_result = {1'b0, a ^ b};
            alu_pkg::OP_NOT:  exec.next_result = {1'b0, ~a};
            alu_pkg::OP_NEG:  exec.next_result = {1'b0, -a};
            // full shift amount, large shifts clear the result
            alu_pkg::OP_SHL:  exec.next_result = a_ext << b;
            alu_pkg::OP_SHR:  exec.next_result = a_ext >> b;
            alu_pkg::OP_SAR:  exec.next_result = {1'b0, sar_res};
            alu_pkg::OP_ROL:  exec.next_result = {1'b0, rol_wide[2*`ALU_DATA_W-1:`ALU_DATA_W]};
            alu_pkg::OP_SET:  exec.next_result = {{`ALU_DATA_W{1'b0}}, take};
            alu_pkg::OP_JMP,
            alu_pkg::OP_CALL: exec.next_result = {1'b0, jump_target};
            alu_pkg::OP_LD,
            alu_pkg::OP_ST:   exec.next_result = {1'b0, mem_addr};
            default:          exec.next_result = '0;
        endcase
    end

    // signs for the overflow check in the result register
    assign exec.a_sign = a[`ALU_DATA_W-1];
    assign exec.b_sign = subtract ? ~b[`ALU_DATA_W-1] : b[`ALU_DATA_W-1];

    assign exec.store_data = rd_data;

endmodule

`default_nettype wire

//--- logic/alu_decode.sv
`timescale 1ns/10ps
`default_nettype none

module alu_decode (
    input  alu_pkg::alu_op_e op,
    input  logic             take,
    alu_exec_if.decode       exec
);

    // overflow is only meaningful for the add and subtract family
    always_comb begin
        case (op)
            alu_pkg::OP_ADD,
            alu_pkg::OP_SUB,
            alu_pkg::OP_ADC,
            alu_pkg::OP_SBB,
            alu_pkg::OP_CMP: exec.ov_op = 1'b1;
            default:         exec.ov_op = 1'b0;
        endcase
    end

    // ops that only set flags, move control flow or write memory
    always_comb begin
        case (op)
            alu_pkg::OP_CMP,
            alu_pkg::OP_TEST,
            alu_pkg::OP_ST,
            alu_pkg::OP_JMP,
            alu_pkg::OP_CALL: exec.write_n = 1'b0;
            default:          exec.write_n = 1'b1;
        endcase
    end

    always_comb begin
        exec.branch_n = 1'b0;
        exec.link_n   = 1'b0;
        case (op)
            alu_pkg::OP_JMP: begin
                exec.branch_n = take;
            end
            alu_pkg::OP_CALL: begin
                // taken call also saves the return address
                exec.branch_n = take;
                exec.link_n   = take;
            end
            default: begin
                exec.branch_n = 1'b0;
                exec.link_n   = 1'b0;
            end
        endcase
    end

    assign exec.store_capture = (op == alu_pkg::OP_ST);

endmodule

`default_nettype wire

//--- logic/alu_exec_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_defines.svh"

// values the result register loads on the next enabled edge
interface alu_exec_if;

    // bit 16 is the carry out
    logic [`ALU_DATA_W:0]   next_result;
    logic                   a_sign;
    // already inverted for subtracting ops
    logic                   b_sign;
    logic [`ALU_DATA_W-1:0] store_data;

    logic ov_op;
    logic write_n;
    logic branch_n;
    logic link_n;
    logic store_capture;

    modport datapath (output next_result, a_sign, b_sign, store_data);

    modport decode (output ov_op, write_n, branch_n, link_n, store_capture);

    modport sink (
        input next_result, a_sign, b_sign, store_data,
        input ov_op, write_n, branch_n, link_n, store_capture
    );

endinterface

`default_nettype wire

//--- logic/alu_pkg.sv
`default_nettype none

`include "alu_defines.svh"

package alu_pkg;

    // opcodes, values fixed by the instruction encoding
    typedef enum logic [`ALU_OP_W-1:0] {
        OP_ADD  = 8'h00,
        OP_SUB  = 8'h01,
        OP_ADC  = 8'h02,
        OP_SBB  = 8'h03,
        OP_CMP  = 8'h04,
        OP_MOV  = 8'h05,
        OP_AND  = 8'h06,
        OP_OR   = 8'h07,
        OP_XOR  = 8'h08,
        OP_NOT  = 8'h09,
        OP_NEG  = 8'h0a,
        OP_SHL  = 8'h0b,
        OP_SHR  = 8'h0c,
        OP_SAR  = 8'h0d,
        OP_ROL  = 8'h0e,
        OP_TEST = 8'h0f,
        OP_SET  = 8'h10,
        OP_JMP  = 8'h11,
        OP_CALL = 8'h12,
        OP_LD   = 8'h13,
        OP_ST   = 8'h14
    } alu_op_e;

    // branch conditions, evaluated against incoming flags
    typedef enum logic [`ALU_COND_W-1:0] {
        COND_ALWAYS, COND_NEVER, COND_EQ, COND_NE,
        COND_CS,     COND_CC,    COND_OS, COND_OC,
        COND_P,      COND_N,     COND_HI, COND_LS,
        COND_GE,     COND_L,     COND_G,  COND_LE
    } alu_cond_e;

    // bit 3 down to bit 0
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } alu_flags_t;

endpackage

`default_nettype wire

//--- logic/alu_result_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_defines.svh"

module alu_result_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    alu_exec_if.sink               exec,
    output logic [`ALU_DATA_W-1:0] result,
    output alu_pkg::alu_flags_t    flags_out,
    output logic                   write,
    output logic                   should_branch,
    output logic                   lr_wr_en,
    output logic [`ALU_DATA_W-1:0] mem_data
);

    logic [`ALU_DATA_W:0]   result_q;
    logic                   ov_q;
    logic [`ALU_DATA_W-1:0] mem_data_q;
    logic                   ov_next;

    // same sign operands giving a result of the other sign
    assign ov_next = exec.ov_op && (exec.a_sign == exec.b_sign) &&
                     (exec.a_sign != exec.next_result[`ALU_DATA_W-1]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q      <= '0;
            ov_q          <= 1'b0;
            write         <= 1'b0;
            should_branch <= 1'b0;
            lr_wr_en      <= 1'b0;
            mem_data_q    <= '0;
        end else if (en) begin
            result_q      <= exec.next_result;
            ov_q          <= ov_next;
            write         <= exec.write_n;
            should_branch <= exec.branch_n;
            lr_wr_en      <= exec.link_n;
            // store data only moves on ST
            if (exec.store_capture) begin
                mem_data_q <= exec.store_data;
            end
        end
    end

    assign result   = result_q[`ALU_DATA_W-1:0];
    assign mem_data = mem_data_q;

    // z, n, c follow the registered result
    assign flags_out.z = (result_q[`ALU_DATA_W-1:0] == '0);
    assign flags_out.n = result_q[`ALU_DATA_W-1];
    assign flags_out.c = result_q[`ALU_DATA_W];
    assign flags_out.v = ov_q;

endmodule

`default_nettype wire

//--- logic/alu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_defines.svh"

module alu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [`ALU_OP_W-1:0]   alu_control,
    input  logic                   en_imm,
    input  logic [`ALU_DATA_W-1:0] rd_data,
    input  logic [`ALU_DATA_W-1:0] rs_data,
    input  logic [`ALU_DATA_W-1:0] immediate,
    input  logic [`ALU_COND_W-1:0] condition,
    input  logic [`ALU_FLAG_W-1:0] flags_in,
    input  logic                   mem_displacement,
    output logic [`ALU_DATA_W-1:0] result,
    output logic [`ALU_FLAG_W-1:0] flags_out,
    output logic                   write,
    output logic                   should_branch,
    output logic                   lr_wr_en,
    output logic [`ALU_DATA_W-1:0] mem_data
);

    alu_pkg::alu_op_e    op;
    alu_pkg::alu_cond_e  cond;
    alu_pkg::alu_flags_t flags_in_s;
    alu_pkg::alu_flags_t flags_q;
    logic                take;

    // raw buses onto package types
    assign op         = alu_pkg::alu_op_e'(alu_control);
    assign cond       = alu_pkg::alu_cond_e'(condition);
    assign flags_in_s = alu_pkg::alu_flags_t'(flags_in);

    alu_exec_if exec_bus ();

    alu_cond_eval u_cond_eval (
        .flags_in  (flags_in_s),
        .condition (cond),
        .take      (take)
    );

    alu_decode u_decode (
        .op   (op),
        .take (take),
        .exec (exec_bus.decode)
    );

    alu_datapath u_datapath (
        .op               (op),
        .en_imm           (en_imm),
        .mem_displacement (mem_displacement),
        .rd_data          (rd_data),
        .rs_data          (rs_data),
        .immediate        (immediate),
        .flags_in         (flags_in_s),
        .take             (take),
        .exec             (exec_bus.datapath)
    );

    // single pipeline stage for every output
    alu_result_reg u_result_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .exec          (exec_bus.sink),
        .result        (result),
        .flags_out     (flags_q),
        .write         (write),
        .should_branch (should_branch),
        .lr_wr_en      (lr_wr_en),
        .mem_data      (mem_data)
    );

    assign flags_out = flags_q;

endmodule

`default_nettype wire

//--- sim/alu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_defines.svh"

module alu_tb;

    localparam int NUM_OPS    = 3000;
    localparam int CLK_PERIOD = 100;

    logic                   clk;
    logic                   rst_n;
    logic                   en;
    logic [`ALU_OP_W-1:0]   alu_control;
    logic                   en_imm;
    logic [`ALU_DATA_W-1:0] rd_data;
    logic [`ALU_DATA_W-1:0] rs_data;
    logic [`ALU_DATA_W-1:0] immediate;
    logic [`ALU_COND_W-1:0] condition;
    logic [`ALU_FLAG_W-1:0] flags_in;
    logic                   mem_displacement;
    logic [`ALU_DATA_W-1:0] result;
    logic [`ALU_FLAG_W-1:0] flags_out;
    logic                   write;
    logic                   should_branch;
    logic                   lr_wr_en;
    logic [`ALU_DATA_W-1:0] mem_data;

    // reference model state, bit 16 of exp_res is the carry
    logic [`ALU_DATA_W:0]   exp_res;
    logic                   exp_v;
    logic                   exp_write;
    logic                   exp_branch;
    logic                   exp_link;
    logic [`ALU_DATA_W-1:0] exp_mem;

    int seed;

    alu_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .en               (en),
        .alu_control      (alu_control),
        .en_imm           (en_imm),
        .rd_data          (rd_data),
        .rs_data          (rs_data),
        .immediate        (immediate),
        .condition        (condition),
        .flags_in         (flags_in),
        .mem_displacement (mem_displacement),
        .result           (result),
        .flags_out        (flags_out),
        .write            (write),
        .should_branch    (should_branch),
        .lr_wr_en         (lr_wr_en),
        .mem_data         (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // reset plus every operation, with some margin
    initial begin
        #((NUM_OPS + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", NUM_OPS + 20);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    // flags are v n c z from bit 3 down
    function automatic logic cond_taken(input logic [3:0] cc, input logic [3:0] f);
        logic v;
        logic n;
        logic c;
        logic z;
        v = f[3];
        n = f[2];
        c = f[1];
        z = f[0];
        case (cc)
            4'd0:    cond_taken = 1'b1;
            4'd1:    cond_taken = 1'b0;
            4'd2:    cond_taken = z;
            4'd3:    cond_taken = !z;
            4'd4:    cond_taken = c;
            4'd5:    cond_taken = !c;
            4'd6:    cond_taken = v;
            4'd7:    cond_taken = !v;
            4'd8:    cond_taken = !n;
            4'd9:    cond_taken = n;
            4'd10:   cond_taken = !c && !z;
            4'd11:   cond_taken = c || z;
            4'd12:   cond_taken = (n == v);
            4'd13:   cond_taken = (n != v);
            4'd14:   cond_taken = !z && (n == v);
            default: cond_taken = z || (n != v);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        if (got !== expected) begin
            $display("Fail: %s got 0x%h expected 0x%h", name, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs;
        logic [3:0] exp_flags;
        exp_flags = {exp_v, exp_res[15], exp_res[16], (exp_res[15:0] == 16'h0000)};
        check_value("result", result, exp_res[15:0]);
        check_value("flags_out", {12'h000, flags_out}, {12'h000, exp_flags});
        check_value("write", {15'h0000, write}, {15'h0000, exp_write});
        check_value("should_branch", {15'h0000, should_branch}, {15'h0000, exp_branch});
        check_value("lr_wr_en", {15'h0000, lr_wr_en}, {15'h0000, exp_link});
        check_value("mem_data", mem_data, exp_mem);
    endtask

    // what the DUT loads on this edge, from the inputs it samples now
    task automatic apply_model;
        logic [15:0] a;
        logic [15:0] b;
        logic [16:0] r;
        logic        take;
        logic        cin;
        if (en) begin
            a    = rd_data;
            b    = en_imm ? immediate : rs_data;
            cin  = flags_in[1];
            take = cond_taken(condition, flags_in);
            r    = '0;
            case (alu_control)
                alu_pkg::OP_ADD:  r = {1'b0, a} + {1'b0, b};
                alu_pkg::OP_SUB,
                alu_pkg::OP_CMP:  r = {1'b0, a} - {1'b0, b};
                alu_pkg::OP_ADC:  r = {1'b0, a} + {1'b0, b} + {16'h0000, cin};
                alu_pkg::OP_SBB:  r = {1'b0, a} - {1'b0, b} - {16'h0000, cin};
                alu_pkg::OP_MOV:  r = {1'b0, b};
                alu_pkg::OP_AND,
                alu_pkg::OP_TEST: r = {1'b0, a & b};
                alu_pkg::OP_OR:   r = {1'b0, a | b};
                alu_pkg::OP_XOR:  r = {1'b0, a ^ b};
                alu_pkg::OP_NOT:  r = {1'b0, ~a};
                alu_pkg::OP_NEG:  r = {1'b0, ~a + 16'h0001};
                alu_pkg::OP_SHL: begin
                    if (b < 17) r = {1'b0, a} << b;
                end
                alu_pkg::OP_SHR: begin
                    if (b < 17) r = {1'b0, a} >> b;
                end
                alu_pkg::OP_SAR: begin
                    r[15:0] = a;
                    repeat (b[3:0]) r[15:0] = {r[15], r[15:1]};
                end
                alu_pkg::OP_ROL: begin
                    r[15:0] = a;
                    repeat (b[3:0]) r[15:0] = {r[14:0], r[15]};
                end
                alu_pkg::OP_SET:  r = {16'h0000, take};
                alu_pkg::OP_JMP,
                alu_pkg::OP_CALL: r = {1'b0, (en_imm ? immediate : a)};
                alu_pkg::OP_LD,
                alu_pkg::OP_ST:   r = {1'b0, (mem_displacement ? rs_data + immediate : b)};
                default:          r = '0;
            endcase
            exp_res = r;
            // signed overflow of the add and subtract family
            case (alu_control)
                alu_pkg::OP_ADD,
                alu_pkg::OP_ADC:  exp_v = (a[15] == b[15]) && (r[15] != a[15]);
                alu_pkg::OP_SUB,
                alu_pkg::OP_SBB,
                alu_pkg::OP_CMP:  exp_v = (a[15] != b[15]) && (r[15] != a[15]);
                default:          exp_v = 1'b0;
            endcase
            case (alu_control)
                alu_pkg::OP_CMP,
                alu_pkg::OP_TEST,
                alu_pkg::OP_ST,
                alu_pkg::OP_JMP,
                alu_pkg::OP_CALL: exp_write = 1'b0;
                default:          exp_write = 1'b1;
            endcase
            exp_branch = take && ((alu_control == alu_pkg::OP_JMP) ||
                                  (alu_control == alu_pkg::OP_CALL));
            exp_link   = take && (alu_control == alu_pkg::OP_CALL);
            if (alu_control == alu_pkg::OP_ST) exp_mem = rd_data;
        end
    endtask

    task automatic drive_random;
        logic [31:0] pick;
        logic [7:0]  op_v;
        logic [15:0] rd_v;
        logic [15:0] rs_v;
        logic [15:0] imm_v;
        pick = $random(seed);
        // an undefined opcode about one time in thirty-two
        if (pick[7:3] == 5'd0) op_v = 8'h15 + ($unsigned($random(seed)) % 235);
        else op_v = $unsigned($random(seed)) % 21;
        rd_v  = $random(seed);
        rs_v  = $random(seed);
        imm_v = $random(seed);
        // small values so shifts and rotates see short amounts
        if (pick[9:8] == 2'd0) begin
            rs_v  = rs_v & 16'h001f;
            imm_v = imm_v & 16'h001f;
        end
        // equal operands give zero results on subtract
        if (pick[10]) rd_v = pick[11] ? imm_v : rs_v;
        en               <= (pick[2:0] != 3'd0);
        alu_control      <= op_v;
        en_imm           <= pick[11];
        mem_displacement <= pick[12];
        condition        <= pick[16:13];
        flags_in         <= pick[20:17];
        rd_data          <= rd_v;
        rs_data          <= rs_v;
        immediate        <= imm_v;
    endtask

    initial begin
        seed             = 23868;
        rst_n            = 1'b0;
        en               = 1'b0;
        alu_control      = '0;
        en_imm           = 1'b0;
        rd_data          = '0;
        rs_data          = '0;
        immediate        = '0;
        condition        = '0;
        flags_in         = '0;
        mem_displacement = 1'b0;
        exp_res          = '0;
        exp_v            = 1'b0;
        exp_write        = 1'b0;
        exp_branch       = 1'b0;
        exp_link         = 1'b0;
        exp_mem          = '0;

        // four reset edges, released on the last one
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs();

        for (int i = 0; i < NUM_OPS; i++) begin
            @(posedge clk);
            apply_model();
            drive_random();
            @(negedge clk);
            check_outputs();
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
logic/alu_pkg.sv
logic/alu_exec_if.sv
logic/alu_cond_eval.sv
logic/alu_decode.sv
logic/alu_datapath.sv
logic/alu_result_reg.sv
logic/alu_top.sv
sim/alu_tb.sv
